// ==== Makefile ====
# Verilator build and run for the memory controller port bridge

TOP = tb_mc_bridge
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f mc_bridge_top.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

# A failed run leaves no pass line in the log, so grep returns an error
run: compile
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/mc_bridge_pkg.sv ====
`include "mc_bridge_settings.svh"

package mc_bridge_pkg;

	// Field widths with a meaning of their own
	typedef logic [`MC_TID_W-1:0] mc_tid_t;
	typedef logic [`MC_VADR_W-1:0] mc_vadr_t;
	typedef logic [`MC_DATA_W-1:0] mc_data_t;
	typedef logic [`MC_SIZE_W-1:0] mc_size_t;
	typedef logic [`MC_SCMD_W-1:0] mc_scmd_t;
	typedef logic [`MC_QW_W-1:0] mc_qw_idx_t;

	// Read response tag is rtnctl without its quadword index bits
	typedef logic [`MC_TID_W-`MC_QW_W-1:0] mc_tag_t;

	// Thread-side operation, both upper codes are atomics
	typedef enum logic [`MC_OP_W-1:0] {
		MIF_OP_READ    = 2'd0,
		MIF_OP_WRITE   = 2'd1,
		MIF_OP_ATOM    = 2'd2,
		MIF_OP_ATOM_HI = 2'd3
	} mif_op_e;

	// Controller request commands
	typedef enum logic [`MC_CMD_W-1:0] {
		MC_RQ_RD8    = 3'd1,
		MC_RQ_WR8    = 3'd2,
		MC_RQ_RD64   = 3'd3,
		MC_RQ_WR64   = 3'd6,
		MC_RQ_ATOMIC = 3'd7
	} mc_rq_cmd_e;

	// Controller response commands
	typedef enum logic [`MC_CMD_W-1:0] {
		MC_RS_RD8_DATA    = 3'd1,
		MC_RS_WR_CMP      = 3'd2,
		MC_RS_RD64_DATA   = 3'd3,
		MC_RS_WR64_CMP    = 3'd6,
		MC_RS_ATOMIC_DATA = 3'd7
	} mc_rs_cmd_e;

	// Atomic exchange sub-command
	localparam mc_scmd_t MC_SCMD_ATOM_EXCH = mc_scmd_t'(2);

	// Exchange value for op 3, only the top bit set
	localparam mc_data_t MC_ATOM_HI_DATA = {1'b1, {(`MC_DATA_W-1){1'b0}}};

	// Thread request word, 149 bits
	typedef struct packed {
		mc_size_t size;
		logic     host;
		mif_op_e  op;
		mc_tid_t  tid;
		mc_vadr_t vadr;
		mc_data_t data;
	} mif_req_t;

	// Controller request fields
	typedef struct packed {
		mc_tid_t    rtnctl;
		mc_data_t   data;
		mc_vadr_t   vadr;
		mc_size_t   size;
		mc_rq_cmd_e cmd;
		mc_scmd_t   scmd;
	} mc_rq_t;

	// Controller response fields, 103 bits
	typedef struct packed {
		mc_rs_cmd_e cmd;
		mc_scmd_t   scmd;
		mc_data_t   data;
		mc_tid_t    rtnctl;
	} mc_rs_t;

	// Read response toward the thread unit, 96 bits
	typedef struct packed {
		mc_tag_t    tag;
		mc_qw_idx_t qw_idx;
		mc_data_t   data;
	} mif_rd_rsp_t;

endpackage

// ==== hdl/mc_bridge_top.sv ====
`include "mc_bridge_settings.svh"

module mc_bridge_top #(
	parameter int NUM_PORTS = `MC_NUM_PORTS
) (
	// Thread unit memory interfaces
	input  mc_bridge_pkg::mif_req_t    [NUM_PORTS-1:0] i_mif_req,
	input  logic                       [NUM_PORTS-1:0] i_mif_req_rdy,
	output logic                       [NUM_PORTS-1:0] o_mif_req_full,
	output mc_bridge_pkg::mif_rd_rsp_t [NUM_PORTS-1:0] o_mif_rd_rsp,
	output logic                       [NUM_PORTS-1:0] o_mif_rd_rsp_rdy,
	input  logic                       [NUM_PORTS-1:0] i_mif_rd_rsp_full,
	output mc_bridge_pkg::mc_tid_t     [NUM_PORTS-1:0] o_mif_wr_rsp_tid,
	output logic                       [NUM_PORTS-1:0] o_mif_wr_rsp_rdy,
	input  logic                       [NUM_PORTS-1:0] i_mif_wr_rsp_full,

	// Memory controller ports
	output mc_bridge_pkg::mc_rq_t      [NUM_PORTS-1:0] o_mc_rq,
	output logic                       [NUM_PORTS-1:0] o_mc_rq_vld,
	input  logic                       [NUM_PORTS-1:0] i_mc_rq_stall,
	input  mc_bridge_pkg::mc_rs_t      [NUM_PORTS-1:0] i_mc_rs,
	input  logic                       [NUM_PORTS-1:0] i_mc_rs_vld,
	output logic                       [NUM_PORTS-1:0] o_mc_rs_stall
);

	// Request valid and stall are plain levels, no buffering
	assign o_mc_rq_vld = i_mif_req_rdy;
	assign o_mif_req_full = i_mc_rq_stall;

	// One encoder and one decoder per port
	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		mif_req_encoder u_req_enc (
			.i_req (i_mif_req[p]),
			.o_rq  (o_mc_rq[p])
		);

		mc_rsp_decoder u_rsp_dec (
			.i_rs          (i_mc_rs[p]),
			.i_rs_vld      (i_mc_rs_vld[p]),
			.i_rd_rsp_full (i_mif_rd_rsp_full[p]),
			.i_wr_rsp_full (i_mif_wr_rsp_full[p]),
			.o_rd_rsp      (o_mif_rd_rsp[p]),
			.o_rd_rsp_rdy  (o_mif_rd_rsp_rdy[p]),
			.o_wr_rsp_tid  (o_mif_wr_rsp_tid[p]),
			.o_wr_rsp_rdy  (o_mif_wr_rsp_rdy[p]),
			.o_rs_stall    (o_mc_rs_stall[p])
		);
	end

endmodule

// ==== hdl/mc_rsp_decoder.sv ====
module mc_rsp_decoder (
	input  mc_bridge_pkg::mc_rs_t      i_rs,
	input  logic                       i_rs_vld,
	input  logic                       i_rd_rsp_full,
	input  logic                       i_wr_rsp_full,
	output mc_bridge_pkg::mif_rd_rsp_t o_rd_rsp,
	output logic                       o_rd_rsp_rdy,
	output mc_bridge_pkg::mc_tid_t     o_wr_rsp_tid,
	output logic                       o_wr_rsp_rdy,
	output logic                       o_rs_stall
);

	import mc_bridge_pkg::*;

	// Response class from the command code
	logic is_rd;
	logic is_wr;

	mc_qw_idx_t qw_idx;

	always_comb begin
		is_rd = 1'b0;
		is_wr = 1'b0;
		case (i_rs.cmd)
			MC_RS_RD8_DATA,
			MC_RS_RD64_DATA,
			MC_RS_ATOMIC_DATA: begin
				is_rd = 1'b1;
			end
			MC_RS_WR_CMP,
			MC_RS_WR64_CMP: begin
				is_wr = 1'b1;
			end
			default: begin
				is_rd = 1'b0;
				is_wr = 1'b0;
			end
		endcase
	end

	// Only rd64 data carries a meaningful quadword index in scmd
	always_comb begin
		if (i_rs.cmd == MC_RS_RD64_DATA) begin
			qw_idx = mc_qw_idx_t'(i_rs.scmd);
		end else begin
			qw_idx = '0;
		end
	end

	// Upper rtnctl bits hold the thread tag
	always_comb begin
		o_rd_rsp.tag = i_rs.rtnctl[$bits(mc_tid_t)-1:$bits(mc_qw_idx_t)];
		o_rd_rsp.qw_idx = qw_idx;
		o_rd_rsp.data = i_rs.data;
	end

	assign o_rd_rsp_rdy = i_rs_vld & is_rd;

	assign o_wr_rsp_tid = i_rs.rtnctl;
	assign o_wr_rsp_rdy = i_rs_vld & is_wr;

	// Either response queue full holds the controller
	assign o_rs_stall = i_rd_rsp_full | i_wr_rsp_full;

endmodule

// ==== hdl/mif_req_encoder.sv ====
module mif_req_encoder (
	input  mc_bridge_pkg::mif_req_t i_req,
	output mc_bridge_pkg::mc_rq_t   o_rq
);

	import mc_bridge_pkg::*;

	// Zero low tid bits mean a single 8-byte access
	mc_qw_idx_t tid_lo;
	logic       tid_lo_zero;

	// Next quadword slot for wr64 wraps within the line
	mc_qw_idx_t wr_seq;

	mc_rq_cmd_e cmd;
	mc_scmd_t   scmd;
	mc_data_t   data;

	assign tid_lo = mc_qw_idx_t'(i_req.tid);
	assign tid_lo_zero = (tid_lo == '0);
	assign wr_seq = tid_lo + mc_qw_idx_t'(1);

	// Command selection
	always_comb begin
		case (i_req.op)
			MIF_OP_READ: begin
				if (tid_lo_zero) begin
					cmd = MC_RQ_RD8;
				end else begin
					cmd = MC_RQ_RD64;
				end
			end
			MIF_OP_WRITE: begin
				if (tid_lo_zero) begin
					cmd = MC_RQ_WR8;
				end else begin
					cmd = MC_RQ_WR64;
				end
			end
			default: begin
				cmd = MC_RQ_ATOMIC;
			end
		endcase
	end

	// Sub-command follows the chosen command
	always_comb begin
		case (cmd)
			MC_RQ_WR64: begin
				scmd = mc_scmd_t'(wr_seq);
			end
			MC_RQ_ATOMIC: begin
				scmd = MC_SCMD_ATOM_EXCH;
			end
			default: begin
				scmd = '0;
			end
		endcase
	end

	// Op 3 swaps in the fixed exchange value
	always_comb begin
		if (i_req.op == MIF_OP_ATOM_HI) begin
			data = MC_ATOM_HI_DATA;
		end else begin
			data = i_req.data;
		end
	end

	// Host flag has no controller field and is dropped here
	always_comb begin
		o_rq.rtnctl = i_req.tid;
		o_rq.data = data;
		o_rq.vadr = i_req.vadr;
		o_rq.size = i_req.size;
		o_rq.cmd = cmd;
		o_rq.scmd = scmd;
	end

endmodule

// ==== include/mc_bridge_settings.svh ====
`ifndef MC_BRIDGE_SETTINGS_SVH
`define MC_BRIDGE_SETTINGS_SVH

// Number of memory controller ports served by the bridge
`define MC_NUM_PORTS 4

// Transaction id, returned unchanged as controller rtnctl
`define MC_TID_W 32

// Virtual address width
`define MC_VADR_W 48

// Data path width
`define MC_DATA_W 64

// Access size code
`define MC_SIZE_W 2

// Thread-side operation code
`define MC_OP_W 2

// Controller request and response command codes
`define MC_CMD_W 3

// Controller sub-command
`define MC_SCMD_W 4

// Quadword index within a 64-byte line, also the low tid bits
`define MC_QW_W 3

`endif

// ==== mc_bridge_top.f ====
+incdir+include
hdl/mc_bridge_pkg.sv
hdl/mif_req_encoder.sv
hdl/mc_rsp_decoder.sv
hdl/mc_bridge_top.sv
sim/tb_mc_bridge.sv

// ==== sim/tb_mc_bridge.sv ====
`include "mc_bridge_settings.svh"

module tb_mc_bridge;

	import mc_bridge_pkg::*;

	localparam int NUM_PORTS = `MC_NUM_PORTS;
	localparam int RST_CYCLES = 5;
	localparam int RAND_CYCLES = 2000;
	localparam int DIR_CYCLES = 34;
	localparam int TOTAL_CYCLES = RST_CYCLES + RAND_CYCLES + DIR_CYCLES + 2;
	localparam int TIMEOUT = (TOTAL_CYCLES + 100) * 100;
	localparam int CW = 192;

	typedef logic [CW-1:0] cmp_t;

	// Expected outputs of one response decoder
	typedef struct packed {
		mif_rd_rsp_t rd_rsp;
		logic        rd_rdy;
		mc_tid_t     wr_tid;
		logic        wr_rdy;
		logic        rs_stall;
	} dec_exp_t;

	logic clk = 1'b0;
	logic rst = 1'b1;

	logic [31:0] lfsr_state = 32'd4;
	int          errors = 0;
	int          checks_done = 0;

	mif_req_t    [NUM_PORTS-1:0] i_mif_req;
	logic        [NUM_PORTS-1:0] i_mif_req_rdy;
	logic        [NUM_PORTS-1:0] o_mif_req_full;
	mif_rd_rsp_t [NUM_PORTS-1:0] o_mif_rd_rsp;
	logic        [NUM_PORTS-1:0] o_mif_rd_rsp_rdy;
	logic        [NUM_PORTS-1:0] i_mif_rd_rsp_full;
	mc_tid_t     [NUM_PORTS-1:0] o_mif_wr_rsp_tid;
	logic        [NUM_PORTS-1:0] o_mif_wr_rsp_rdy;
	logic        [NUM_PORTS-1:0] i_mif_wr_rsp_full;
	mc_rq_t      [NUM_PORTS-1:0] o_mc_rq;
	logic        [NUM_PORTS-1:0] o_mc_rq_vld;
	logic        [NUM_PORTS-1:0] i_mc_rq_stall;
	mc_rs_t      [NUM_PORTS-1:0] i_mc_rs;
	logic        [NUM_PORTS-1:0] i_mc_rs_vld;
	logic        [NUM_PORTS-1:0] o_mc_rs_stall;

	mc_bridge_top #(
		.NUM_PORTS (NUM_PORTS)
	) u_dut (
		.i_mif_req         (i_mif_req),
		.i_mif_req_rdy     (i_mif_req_rdy),
		.o_mif_req_full    (o_mif_req_full),
		.o_mif_rd_rsp      (o_mif_rd_rsp),
		.o_mif_rd_rsp_rdy  (o_mif_rd_rsp_rdy),
		.i_mif_rd_rsp_full (i_mif_rd_rsp_full),
		.o_mif_wr_rsp_tid  (o_mif_wr_rsp_tid),
		.o_mif_wr_rsp_rdy  (o_mif_wr_rsp_rdy),
		.i_mif_wr_rsp_full (i_mif_wr_rsp_full),
		.o_mc_rq           (o_mc_rq),
		.o_mc_rq_vld       (o_mc_rq_vld),
		.i_mc_rq_stall     (i_mc_rq_stall),
		.i_mc_rs           (i_mc_rs),
		.i_mc_rs_vld       (i_mc_rs_vld),
		.o_mc_rs_stall     (o_mc_rs_stall)
	);

	always #50 clk = ~clk;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[62:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic mc_rq_t ref_encode(input mif_req_t req);
		mc_rq_t     rq;
		logic [2:0] lo;
		lo = req.tid[2:0];
		rq.rtnctl = req.tid;
		rq.vadr = req.vadr;
		rq.size = req.size;
		rq.data = req.data;
		rq.scmd = 4'd0;
		if (req.op == MIF_OP_READ) begin
			rq.cmd = (lo == 3'd0) ? MC_RQ_RD8 : MC_RQ_RD64;
		end else if (req.op == MIF_OP_WRITE) begin
			if (lo == 3'd0) begin
				rq.cmd = MC_RQ_WR8;
			end else begin
				rq.cmd = MC_RQ_WR64;
				// Next quadword, wraps inside three bits
				rq.scmd = {1'b0, 3'(lo + 3'd1)};
			end
		end else begin
			rq.cmd = MC_RQ_ATOMIC;
			rq.scmd = 4'd2;
			if (req.op == MIF_OP_ATOM_HI) begin
				rq.data = 64'h8000_0000_0000_0000;
			end
		end
		return rq;
	endfunction

	function automatic dec_exp_t ref_decode(input mc_rs_t rs, input logic vld,
		input logic rd_full, input logic wr_full);
		dec_exp_t e;
		logic     rd_cls;
		logic     wr_cls;
		rd_cls = (rs.cmd == MC_RS_RD8_DATA) || (rs.cmd == MC_RS_RD64_DATA) ||
			(rs.cmd == MC_RS_ATOMIC_DATA);
		wr_cls = (rs.cmd == MC_RS_WR_CMP) || (rs.cmd == MC_RS_WR64_CMP);
		e.rd_rsp.tag = rs.rtnctl[31:3];
		e.rd_rsp.qw_idx = (rs.cmd == MC_RS_RD64_DATA) ? rs.scmd[2:0] : 3'd0;
		e.rd_rsp.data = rs.data;
		e.rd_rdy = vld & rd_cls;
		e.wr_tid = rs.rtnctl;
		e.wr_rdy = vld & wr_cls;
		e.rs_stall = rd_full | wr_full;
		return e;
	endfunction

	task automatic check_val(input string name, input cmp_t got, input cmp_t exp);
		checks_done++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "Output mismatch on %s", name);
		end
	endtask

	task automatic compare_outputs();
		mc_rq_t   exp_rq;
		dec_exp_t exp_dec;
		// Quiet state while the bench holds reset
		if (rst) begin
			check_val("o_mc_rq_vld", cmp_t'(o_mc_rq_vld), '0);
			check_val("o_mif_rd_rsp_rdy", cmp_t'(o_mif_rd_rsp_rdy), '0);
			check_val("o_mif_wr_rsp_rdy", cmp_t'(o_mif_wr_rsp_rdy), '0);
		end
		for (int p = 0; p < NUM_PORTS; p++) begin
			exp_rq = ref_encode(i_mif_req[p]);
			exp_dec = ref_decode(i_mc_rs[p], i_mc_rs_vld[p], i_mif_rd_rsp_full[p],
				i_mif_wr_rsp_full[p]);
			check_val($sformatf("o_mc_rq[%0d]", p), cmp_t'(o_mc_rq[p]), cmp_t'(exp_rq));
			check_val($sformatf("o_mc_rq_vld[%0d]", p), cmp_t'(o_mc_rq_vld[p]),
				cmp_t'(i_mif_req_rdy[p]));
			check_val($sformatf("o_mif_req_full[%0d]", p), cmp_t'(o_mif_req_full[p]),
				cmp_t'(i_mc_rq_stall[p]));
			check_val($sformatf("o_mif_rd_rsp[%0d]", p), cmp_t'(o_mif_rd_rsp[p]),
				cmp_t'(exp_dec.rd_rsp));
			check_val($sformatf("o_mif_rd_rsp_rdy[%0d]", p), cmp_t'(o_mif_rd_rsp_rdy[p]),
				cmp_t'(exp_dec.rd_rdy));
			check_val($sformatf("o_mif_wr_rsp_tid[%0d]", p), cmp_t'(o_mif_wr_rsp_tid[p]),
				cmp_t'(exp_dec.wr_tid));
			check_val($sformatf("o_mif_wr_rsp_rdy[%0d]", p), cmp_t'(o_mif_wr_rsp_rdy[p]),
				cmp_t'(exp_dec.wr_rdy));
			check_val($sformatf("o_mc_rs_stall[%0d]", p), cmp_t'(o_mc_rs_stall[p]),
				cmp_t'(exp_dec.rs_stall));
		end
	endtask

	// Outputs are combinational and settled by the falling edge
	always @(negedge clk) begin
		compare_outputs();
	end

	task automatic drive_idle();
		i_mif_req <= '0;
		i_mif_req_rdy <= '0;
		i_mif_rd_rsp_full <= '0;
		i_mif_wr_rsp_full <= '0;
		i_mc_rq_stall <= '0;
		i_mc_rs <= '0;
		i_mc_rs_vld <= '0;
	endtask

	task automatic drive_random();
		mif_req_t req;
		mc_rs_t   rs;
		for (int p = 0; p < NUM_PORTS; p++) begin
			req.size = mc_size_t'(rand_bits(2));
			req.host = 1'(rand_bits(1));
			req.op = mif_op_e'(2'(rand_bits(2)));
			req.tid = mc_tid_t'(rand_bits(32));
			req.vadr = mc_vadr_t'(rand_bits(48));
			req.data = mc_data_t'(rand_bits(64));
			rs.cmd = mc_rs_cmd_e'(3'(rand_bits(3)));
			rs.scmd = mc_scmd_t'(rand_bits(4));
			rs.data = mc_data_t'(rand_bits(64));
			rs.rtnctl = mc_tid_t'(rand_bits(32));
			i_mif_req[p] <= req;
			i_mc_rs[p] <= rs;
			i_mif_req_rdy[p] <= 1'(rand_bits(1));
			i_mc_rq_stall[p] <= 1'(rand_bits(1));
			i_mc_rs_vld[p] <= 1'(rand_bits(1));
			i_mif_rd_rsp_full[p] <= 1'(rand_bits(1));
			i_mif_wr_rsp_full[p] <= 1'(rand_bits(1));
		end
	endtask

	task automatic drive_req(input int p, input mif_op_e op, input mc_tid_t tid,
		input mc_data_t data);
		mif_req_t req;
		req.size = 2'd3;
		req.host = 1'b1;
		req.op = op;
		req.tid = tid;
		req.vadr = 48'h1234_5678_9abc ^ mc_vadr_t'(p);
		req.data = data;
		i_mif_req[p] <= req;
		i_mif_req_rdy[p] <= 1'b1;
	endtask

	task automatic drive_rsp(input int p, input mc_rs_cmd_e cmd, input mc_scmd_t scmd,
		input logic vld);
		mc_rs_t rs;
		rs.cmd = cmd;
		rs.scmd = scmd;
		rs.data = 64'hdead_beef_0bad_f00d;
		rs.rtnctl = 32'ha5c3_9e7f ^ mc_tid_t'(p);
		i_mc_rs[p] <= rs;
		i_mc_rs_vld[p] <= vld;
	endtask

	task automatic run_directed();
		// Read and write command selection, wr64 wrap at tid low bits 7
		@(posedge clk);
		drive_idle();
		drive_req(0, MIF_OP_READ, 32'h0000_1230, 64'h0123_4567_89ab_cdef);
		drive_req(1, MIF_OP_READ, 32'h0000_1235, 64'hfedc_ba98_7654_3210);
		drive_req(2, MIF_OP_WRITE, 32'h0000_4448, 64'h1111_2222_3333_4444);
		drive_req(3, MIF_OP_WRITE, 32'h0000_555f, 64'h5555_6666_7777_8888);
		@(negedge clk);
		check_val("o_mc_rq[0].cmd", cmp_t'(o_mc_rq[0].cmd), cmp_t'(3'd1));
		check_val("o_mc_rq[1].cmd", cmp_t'(o_mc_rq[1].cmd), cmp_t'(3'd3));
		check_val("o_mc_rq[2].cmd", cmp_t'(o_mc_rq[2].cmd), cmp_t'(3'd2));
		check_val("o_mc_rq[3].cmd", cmp_t'(o_mc_rq[3].cmd), cmp_t'(3'd6));
		check_val("o_mc_rq[3].scmd", cmp_t'(o_mc_rq[3].scmd), cmp_t'(4'd0));

		// Both atomics, only op 3 replaces the data
		@(posedge clk);
		drive_idle();
		drive_req(0, MIF_OP_ATOM, 32'h0000_0007, 64'h0f0f_0f0f_0f0f_0f0f);
		drive_req(1, MIF_OP_ATOM_HI, 32'h0000_0007, 64'h0f0f_0f0f_0f0f_0f0f);
		@(negedge clk);
		check_val("o_mc_rq[0].data", cmp_t'(o_mc_rq[0].data), cmp_t'(64'h0f0f_0f0f_0f0f_0f0f));
		check_val("o_mc_rq[1].data", cmp_t'(o_mc_rq[1].data), cmp_t'(64'h8000_0000_0000_0000));
		check_val("o_mc_rq[1].scmd", cmp_t'(o_mc_rq[1].scmd), cmp_t'(4'd2));

		// Every response code, first with valid high then low
		for (int v = 1; v >= 0; v--) begin
			for (int c = 0; c < 8; c++) begin
				@(posedge clk);
				drive_idle();
				drive_rsp(c % NUM_PORTS, mc_rs_cmd_e'(3'(c)), 4'hd, 1'(v));
			end
		end

		// Flags on one port at a time, all other ports idle
		for (int p = 0; p < NUM_PORTS; p++) begin
			for (int f = 0; f < 4; f++) begin
				@(posedge clk);
				drive_idle();
				i_mif_req_rdy[p] <= f[0];
				i_mc_rq_stall[p] <= f[1];
				i_mif_rd_rsp_full[p] <= f[0];
				i_mif_wr_rsp_full[p] <= f[1];
			end
		end
	endtask

	initial begin
		drive_idle();
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int n = 0; n < RAND_CYCLES; n++) begin
			@(posedge clk);
			drive_random();
		end
		run_directed();
		@(posedge clk);
		drive_idle();
		@(posedge clk);
		if (errors == 0 && checks_done > 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Run length bound from the cycle budget
	initial begin
		#(TIMEOUT);
		$display("Watchdog expired before the test sequence finished");
		$display("Result: FAILED");
		$fatal(1, "Timeout");
	end

endmodule
